// File: common/cart_bus_cfg.svh
/*
  build constants for the cartridge slot capture. The scan timing below assumes four
  external 6-bit buffers and a pin map that is fixed by the board wiring
*/
`ifndef CART_BUS_CFG_SVH
`define CART_BUS_CFG_SVH

// one scan frame visits every buffer group once
`define CART_SCAN_STEPS     12
`define CART_MUX_GROUPS     4
`define CART_MUX_WIDTH      6

`define CART_ADDR_WIDTH     16
`define CART_DATA_WIDTH     8

// slot clock delay line length in CLK cycles
`define CART_CLOCK_DELAY    9

// address latch step, after the last address group has been filtered
`define CART_LATCH_STEP     11

// first of the two sample steps of each group window
`define CART_GRP0_STEP      1
`define CART_GRP1_STEP      4
`define CART_GRP2_STEP      7
`define CART_GRP3_STEP      10

// group 2 carries A12..A15 on bits 0..3 and the two strobes above them
`define CART_BIT_RD         4
`define CART_BIT_WR         5

// group 3 carries the slot control lines
`define CART_BIT_RFSH       0
`define CART_BIT_SLTSL      1
`define CART_BIT_MERQ       2
`define CART_BIT_IORQ       3
`define CART_BIT_RESET      4

`endif

// File: common/cart_bus_pkg.sv
/*
  shared types of the slot bus capture, sized from the constants header
*/
`include "cart_bus_cfg.svh"

package cart_bus_pkg;

    // step counter of one scan frame, wide enough for CART_SCAN_STEPS
    typedef logic [$clog2(`CART_SCAN_STEPS)-1:0] scan_step_t;

    // chip-select code of the external buffer decoder
    typedef logic [$clog2(`CART_MUX_GROUPS)-1:0] mux_sel_t;

    // pins of one buffer group as seen on the shared inputs
    typedef logic [`CART_MUX_WIDTH-1:0] mux_group_t;

    // one sample enable per buffer group
    typedef logic [`CART_MUX_GROUPS-1:0] group_ena_t;

    // full slot address after reassembly
    typedef logic [`CART_ADDR_WIDTH-1:0] addr_t;

    // slot data byte in either direction
    typedef logic [`CART_DATA_WIDTH-1:0] data_t;

endpackage

// File: hdl/pin_filter.sv
/*
  two-sample agreement filter. A bit only moves when two consecutive enabled samples
  agree, so a glitch shorter than one enabled sample is dropped. Resets to all ones
*/
`timescale 1ns/100ps

module pin_filter #(
    parameter type filter_t = logic
) (
    input  logic    CLK,
    input  logic    RESET_n,
    input  logic    ena,
    input  filter_t pins,
    output filter_t filtered
);

    // sample taken at the previous enabled edge
    filter_t prev;

    // bits where the new sample confirms the previous one
    filter_t agree;

    assign agree = ~(prev ^ pins);

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            prev     <= '1;
            filtered <= '1;
        end else if (ena) begin
            prev <= pins;
            // confirmed bits take the new value, the rest keep their output
            filtered <= (pins & agree) | (filtered & ~agree);
        end
    end

endmodule

// File: mux_scan/mux_scanner.sv
/*
  12-step scan of the four slot buffers. The select changes on the falling edge and each
  group is selected one cycle before its two sample steps, so the buffers can settle
*/
`timescale 1ns/100ps
`include "cart_bus_cfg.svh"

module mux_scanner
    import cart_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET_n,
    output mux_sel_t   cart_mux_cs,
    output group_ena_t group_ena,
    output scan_step_t scan_step
);

    localparam scan_step_t LAST_STEP = scan_step_t'(`CART_SCAN_STEPS - 1);

    // sample step counter on the rising edge
    scan_step_t step_in;

    // select step counter on the falling edge
    scan_step_t step_sel;

    // holds the falling-edge logic cleared until the first rising edge after reset
    logic sel_run;

    // buffer select code for one step of the select counter
    function automatic mux_sel_t sel_code(input scan_step_t step);
        mux_sel_t code;
        case (step)
            4'd1, 4'd2, 4'd3: code = 2'd1;
            4'd4, 4'd5, 4'd6: code = 2'd2;
            4'd7, 4'd8, 4'd9: code = 2'd3;
            default:          code = 2'd0;
        endcase
        return code;
    endfunction

    // true on the two sample steps that start at first
    function automatic logic in_window(input scan_step_t step, input int first);
        return (step == scan_step_t'(first)) || (step == scan_step_t'(first + 1));
    endfunction

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            step_in <= '0;
        end else if (step_in == LAST_STEP) begin
            step_in <= '0;
        end else begin
            step_in <= step_in + 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            sel_run <= 1'b0;
        end else begin
            sel_run <= 1'b1;
        end
    end

    // the select counter starts at the last step, so at every sampling edge it trails
    // the sample counter by two and the group select is already stable for one cycle
    always_ff @(negedge CLK or negedge sel_run) begin
        if (!sel_run) begin
            step_sel    <= LAST_STEP;
            cart_mux_cs <= '0;
        end else begin
            cart_mux_cs <= sel_code(step_sel);
            if (step_sel == LAST_STEP) begin
                step_sel <= '0;
            end else begin
                step_sel <= step_sel + 1'b1;
            end
        end
    end

    // two sample steps per group, at the end of its select period
    assign group_ena[0] = in_window(step_in, `CART_GRP0_STEP);
    assign group_ena[1] = in_window(step_in, `CART_GRP1_STEP);
    assign group_ena[2] = in_window(step_in, `CART_GRP2_STEP);
    assign group_ena[3] = in_window(step_in, `CART_GRP3_STEP);

    // the capture block latches the address on one of these steps
    assign scan_step = step_in;

endmodule

// File: mux_scan/bus_signal_capture.sv
/*
  filters the four buffer groups and rebuilds the slot address and control lines.
  Bit 5 of group 3 is a spare pin and is not mapped to any output
*/
`timescale 1ns/100ps
`include "cart_bus_cfg.svh"

module bus_signal_capture
    import cart_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET_n,
    input  mux_group_t cart_mux_sig,
    input  group_ena_t group_ena,
    input  scan_step_t scan_step,
    output addr_t      addr,
    output logic       rd_n,
    output logic       wr_n,
    output logic       rfsh_n,
    output logic       sltsl_n,
    output logic       merq_n,
    output logic       iorq_n,
    output logic       slot_reset_n,
    output logic       cs1_n,
    output logic       cs2_n,
    output logic       cs12_n
);

    // filtered pins of every group, held between their sample windows
    mux_group_t grp [`CART_MUX_GROUPS];

    // address straight from the filters, still moving during a frame
    addr_t addr_live;

    // address held for a whole frame
    addr_t addr_q;

    // each filter only looks at the shared pins while its own buffer is selected
    for (genvar g = 0; g < `CART_MUX_GROUPS; g++) begin : g_filter
        pin_filter #(
            .filter_t (mux_group_t)
        ) i_filter (
            .CLK      (CLK),
            .RESET_n  (RESET_n),
            .ena      (group_ena[g]),
            .pins     (cart_mux_sig),
            .filtered (grp[g])
        );
    end

    // A0..A5 in group 0, A6..A11 in group 1, A12..A15 in the low bits of group 2
    assign addr_live = {grp[2][3:0], grp[1], grp[0]};

    // loading after the control group window keeps the address in step with MERQ and IORQ
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            addr_q <= '1;
        end else if (scan_step == scan_step_t'(`CART_LATCH_STEP)) begin
            addr_q <= addr_live;
        end
    end

    assign addr = addr_q;

    // strobes from group 2
    assign rd_n = grp[2][`CART_BIT_RD];
    assign wr_n = grp[2][`CART_BIT_WR];

    // slot control lines from group 3
    assign rfsh_n       = grp[3][`CART_BIT_RFSH];
    assign sltsl_n      = grp[3][`CART_BIT_SLTSL];
    assign merq_n       = grp[3][`CART_BIT_MERQ];
    assign iorq_n       = grp[3][`CART_BIT_IORQ];
    assign slot_reset_n = grp[3][`CART_BIT_RESET];

    // page selects from A15..A14
    // CS1 covers 4000h..7FFFh, CS2 covers 8000h..BFFFh, CS12 covers both
    assign cs1_n  = addr_q[`CART_ADDR_WIDTH-1 -: 2] != 2'b01;
    assign cs2_n  = addr_q[`CART_ADDR_WIDTH-1 -: 2] != 2'b10;
    assign cs12_n = addr_q[`CART_ADDR_WIDTH-1] == addr_q[`CART_ADDR_WIDTH-2];

endmodule

// File: hdl/cart_data_port.sv
/*
  8-bit slot data port. The FPGA drives only during a slot read that the host has
  claimed with busdir_n, otherwise the pins float and are filtered as input
*/
`timescale 1ns/100ps

module cart_data_port
    import cart_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET_n,
    inout  wire data_t cart_data,
    input  logic       rd_n,
    input  logic       busdir_n,
    input  data_t      dout,
    output data_t      din,
    output logic       cart_busdir_n
);

    // high while the FPGA owns the data pins
    logic drive_en;

    assign drive_en = !rd_n && !busdir_n;

    // the external transceiver follows the same direction
    assign cart_busdir_n = !drive_en;

    assign cart_data = drive_en ? dout : 'z;

    // input filter runs every cycle and also sees our own driven value
    pin_filter #(
        .filter_t (data_t)
    ) i_din_filter (
        .CLK      (CLK),
        .RESET_n  (RESET_n),
        .ena      (1'b1),
        .pins     (cart_data),
        .filtered (din)
    );

endmodule

// File: hdl/cart_clock_edge.sv
/*
  slot clock recovery. The clock is filtered, delayed to line up with the captured bus
  and turned into a one-cycle enable. Each clock level must last at least 2 CLK cycles
*/
`timescale 1ns/100ps
`include "cart_bus_cfg.svh"

module cart_clock_edge (
    input  logic CLK,
    input  logic RESET_n,
    input  logic cart_clock,
    output logic bus_clk,
    output logic clk_en
);

    // slot clock after the agreement filter
    logic clock_filt;

    // delay line, bit 0 is the oldest sample
    logic [`CART_CLOCK_DELAY-1:0] delay_q;

    // bus_clk one cycle ago, the tail of the delay line
    logic bus_clk_q;

    pin_filter #(
        .filter_t (logic)
    ) i_clock_filter (
        .CLK      (CLK),
        .RESET_n  (RESET_n),
        .ena      (1'b1),
        .pins     (cart_clock),
        .filtered (clock_filt)
    );

    // the delay matches the clock to the address and control timing of the scan
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            delay_q   <= '1;
            bus_clk_q <= 1'b1;
        end else begin
            delay_q   <= {clock_filt, delay_q[`CART_CLOCK_DELAY-1:1]};
            bus_clk_q <= delay_q[0];
        end
    end

    assign bus_clk = delay_q[0];

    // registered edge so the enable is clean right out of reset
    // since the tail also resets high, no false edge is seen at start
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            clk_en <= 1'b0;
        end else begin
            clk_en <= bus_clk && !bus_clk_q;
        end
    end

endmodule

// File: hdl/cart_bus_top.sv
/*
  cartridge slot bus front end. Address and control arrive through four multiplexed
  buffers and take up to four scan frames (48 CLK cycles) to show on the outputs
*/
`timescale 1ns/100ps

module cart_bus_top
    import cart_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET_n,
    input  logic       cart_clock,
    input  mux_group_t cart_mux_sig,
    input  logic       busdir_n,
    input  data_t      dout,
    input  logic       int_n,
    input  logic       wait_n,
    output mux_sel_t   cart_mux_cs,
    output logic       cart_busdir_n,
    output logic       cart_int_drv,
    output logic       cart_wait_drv,
    output addr_t      addr,
    output data_t      din,
    output logic       rd_n,
    output logic       wr_n,
    output logic       rfsh_n,
    output logic       sltsl_n,
    output logic       merq_n,
    output logic       iorq_n,
    output logic       slot_reset_n,
    output logic       cs1_n,
    output logic       cs2_n,
    output logic       cs12_n,
    output logic       bus_clk,
    output logic       clk_en,
    inout  wire data_t cart_data
);

    // scan timing shared by the scanner and the capture
    group_ena_t group_ena;
    scan_step_t scan_step;

    mux_scanner i_scanner (
        .CLK         (CLK),
        .RESET_n     (RESET_n),
        .cart_mux_cs (cart_mux_cs),
        .group_ena   (group_ena),
        .scan_step   (scan_step)
    );

    bus_signal_capture i_capture (
        .CLK          (CLK),
        .RESET_n      (RESET_n),
        .cart_mux_sig (cart_mux_sig),
        .group_ena    (group_ena),
        .scan_step    (scan_step),
        .addr         (addr),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .rfsh_n       (rfsh_n),
        .sltsl_n      (sltsl_n),
        .merq_n       (merq_n),
        .iorq_n       (iorq_n),
        .slot_reset_n (slot_reset_n),
        .cs1_n        (cs1_n),
        .cs2_n        (cs2_n),
        .cs12_n       (cs12_n)
    );

    // the captured read strobe also sets the data direction
    cart_data_port i_data_port (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .cart_data     (cart_data),
        .rd_n          (rd_n),
        .busdir_n      (busdir_n),
        .dout          (dout),
        .din           (din),
        .cart_busdir_n (cart_busdir_n)
    );

    cart_clock_edge i_clock_edge (
        .CLK        (CLK),
        .RESET_n    (RESET_n),
        .cart_clock (cart_clock),
        .bus_clk    (bus_clk),
        .clk_en     (clk_en)
    );

    // the board drives INT and WAIT through inverting open-collector stages
    assign cart_int_drv  = !int_n;
    assign cart_wait_drv = !wait_n;

endmodule

// File: tests/cart_bus_tb.sv
/*
  testbench for the cartridge slot front end. A buffer model serves the four groups from
  one stored slot state, and each state is held for four scan frames before it is checked
*/
`timescale 1ns/100ps
`include "cart_bus_cfg.svh"

module cart_bus_tb
    import cart_bus_pkg::*;
();

    localparam int CLK_HALF        = 5;
    localparam int DRIVE_DLY       = 1;
    localparam int SAMPLE_DLY      = 4;
    localparam int RESET_CYCLES    = 3;
    localparam int HOLD_CYCLES     = 48;
    localparam int DIN_CYCLES      = 3;
    localparam int CLK_EN_EDGES    = 11;
    localparam int NUM_BUS_TESTS   = 24;
    localparam int NUM_DATA_TESTS  = 8;
    localparam int NUM_CLOCK_TESTS = 20;
    localparam int TIMEOUT_CYCLES  =
        (NUM_BUS_TESTS + NUM_DATA_TESTS + NUM_CLOCK_TESTS) * 60 + 200;

    // outputs that the slot state alone decides
    typedef struct packed {
        addr_t addr;
        logic  rd_n, wr_n, rfsh_n, sltsl_n, merq_n, iorq_n, slot_reset_n;
        logic  cs1_n, cs2_n, cs12_n;
    } bus_view_t;

    logic CLK = 1'b0;
    logic RESET_n, cart_clock, busdir_n, int_n, wait_n;
    data_t dout, host_byte, din;
    mux_group_t cart_mux_sig;
    mux_sel_t cart_mux_cs;
    addr_t addr;
    logic cart_busdir_n, cart_int_drv, cart_wait_drv, bus_clk, clk_en;
    logic rd_n, wr_n, rfsh_n, sltsl_n, merq_n, iorq_n, slot_reset_n, cs1_n, cs2_n, cs12_n;
    wire data_t cart_data;

    // slot state as the four buffers hold it, group g on bits 6g+5..6g
    logic [`CART_MUX_GROUPS*`CART_MUX_WIDTH-1:0] slot_state;

    integer seed = 32'h2c8f;
    logic [31:0] rnd;
    int errors = 0;
    int checks = 0;
    int cycle = 0;
    int rising_edges = 0;
    int pulse_count = 0;
    int pulse_due[$];
    // driven slot clock level of each monitored cycle, oldest first
    logic clock_hist[$];
    logic mon_on = 1'b0;
    event bus_check;

    always #CLK_HALF CLK = ~CLK;

    always @(posedge CLK) cycle <= cycle + 1;

    // external buffers put the selected group on the shared pins
    assign cart_mux_sig = slot_state[cart_mux_cs * `CART_MUX_WIDTH +: `CART_MUX_WIDTH];

    // host side of the data transceiver drives whenever the FPGA does not
    assign cart_data = cart_busdir_n ? host_byte : 'z;

    cart_bus_top i_dut (.*);

    // expected outputs for one slot state, straight from the pin map and page decode
    function automatic bus_view_t expected_bus(input logic [23:0] state);
        bus_view_t v;
        mux_group_t g2, g3;
        g2 = state[2*`CART_MUX_WIDTH +: `CART_MUX_WIDTH];
        g3 = state[3*`CART_MUX_WIDTH +: `CART_MUX_WIDTH];
        v.addr         = {g2[3:0], state[11:0]};
        v.rd_n         = g2[`CART_BIT_RD];
        v.wr_n         = g2[`CART_BIT_WR];
        v.rfsh_n       = g3[`CART_BIT_RFSH];
        v.sltsl_n      = g3[`CART_BIT_SLTSL];
        v.merq_n       = g3[`CART_BIT_MERQ];
        v.iorq_n       = g3[`CART_BIT_IORQ];
        v.slot_reset_n = g3[`CART_BIT_RESET];
        // page 1 is 4000h..7FFFh and page 2 is 8000h..BFFFh
        v.cs1_n  = !(v.addr[15:14] == 2'b01);
        v.cs2_n  = !(v.addr[15:14] == 2'b10);
        v.cs12_n = (v.addr[15:14] == 2'b00) || (v.addr[15:14] == 2'b11);
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        errors++;
        $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
    endtask

    // inputs change a little after the rising edge
    task automatic next_drive();
        @(posedge CLK);
        #DRIVE_DLY;
    endtask

    // din must settle on the host byte within the filter latency
    task automatic wait_din(input data_t expected);
        int waited;
        waited = 0;
        checks++;
        while (din !== expected && waited < DIN_CYCLES) begin
            @(posedge CLK);
            #SAMPLE_DLY;
            waited++;
        end
        if (din !== expected) begin
            $display("din did not reach the host byte within %0d cycles", DIN_CYCLES);
            report_mismatch("din", 32'(din), 32'(expected));
        end
    endtask

    always @(bus_check) begin
        bus_view_t ev;
        ev = expected_bus(slot_state);
        checks++;
        if (addr !== ev.addr) report_mismatch("addr", 32'(addr), 32'(ev.addr));
        if (rd_n !== ev.rd_n) report_mismatch("rd_n", 32'(rd_n), 32'(ev.rd_n));
        if (wr_n !== ev.wr_n) report_mismatch("wr_n", 32'(wr_n), 32'(ev.wr_n));
        if (rfsh_n !== ev.rfsh_n) report_mismatch("rfsh_n", 32'(rfsh_n), 32'(ev.rfsh_n));
        if (sltsl_n !== ev.sltsl_n) report_mismatch("sltsl_n", 32'(sltsl_n), 32'(ev.sltsl_n));
        if (merq_n !== ev.merq_n) report_mismatch("merq_n", 32'(merq_n), 32'(ev.merq_n));
        if (iorq_n !== ev.iorq_n) report_mismatch("iorq_n", 32'(iorq_n), 32'(ev.iorq_n));
        if (slot_reset_n !== ev.slot_reset_n)
            report_mismatch("slot_reset_n", 32'(slot_reset_n), 32'(ev.slot_reset_n));
        if (cs1_n !== ev.cs1_n) report_mismatch("cs1_n", 32'(cs1_n), 32'(ev.cs1_n));
        if (cs2_n !== ev.cs2_n) report_mismatch("cs2_n", 32'(cs2_n), 32'(ev.cs2_n));
        if (cs12_n !== ev.cs12_n) report_mismatch("cs12_n", 32'(cs12_n), 32'(ev.cs12_n));
        if (cart_int_drv !== !int_n)
            report_mismatch("cart_int_drv", 32'(cart_int_drv), 32'(!int_n));
        if (cart_wait_drv !== !wait_n)
            report_mismatch("cart_wait_drv", 32'(cart_wait_drv), 32'(!wait_n));
    end

    // every cycle clk_en must match the pulses scheduled by the driven clock edges
    always @(posedge CLK) begin
        logic exp_en;
        logic exp_bus_clk;
        #SAMPLE_DLY;
        if (mon_on) begin
            exp_en = (pulse_due.size() > 0) && (pulse_due[0] == cycle);
            if (exp_en) void'(pulse_due.pop_front());
            if (clk_en === 1'b1) pulse_count++;
            checks++;
            if (clk_en !== exp_en) report_mismatch("clk_en", 32'(clk_en), 32'(exp_en));
            // bus_clk rises one cycle before clk_en and so trails the driven level
            // by CLK_EN_EDGES cycles
            clock_hist.push_back(cart_clock);
            if (clock_hist.size() > CLK_EN_EDGES) begin
                exp_bus_clk = clock_hist.pop_front();
                checks++;
                if (bus_clk !== exp_bus_clk)
                    report_mismatch("bus_clk", 32'(bus_clk), 32'(exp_bus_clk));
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int high_len;
        int low_len;
        RESET_n    = 1'b0;
        cart_clock = 1'b0;
        busdir_n   = 1'b1;
        dout       = '0;
        host_byte  = '0;
        int_n      = 1'b1;
        wait_n     = 1'b1;
        // an idle slot bus reads as all ones, the same as the reset values
        slot_state = '1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DLY;
        RESET_n = 1'b1;
        mon_on  = 1'b1;
        #(SAMPLE_DLY - DRIVE_DLY);
        -> bus_check;
        checks++;
        if (cart_mux_cs !== '0) report_mismatch("cart_mux_cs", 32'(cart_mux_cs), 32'h0);
        if (cart_busdir_n !== 1'b1) report_mismatch("cart_busdir_n", 32'(cart_busdir_n), 32'h1);

        // the first four states walk A15..A14 through every page
        for (int i = 0; i < NUM_BUS_TESTS; i++) begin
            next_drive();
            rnd = $random(seed);
            slot_state = rnd[23:0];
            if (i < 4) slot_state[15:14] = i[1:0];
            int_n  = rnd[24];
            wait_n = rnd[25];
            repeat (HOLD_CYCLES) @(posedge CLK);
            #SAMPLE_DLY;
            -> bus_check;
        end

        // even tests hold a slot read so the FPGA may drive, odd ones do not
        for (int i = 0; i < NUM_DATA_TESTS; i++) begin
            next_drive();
            rnd = $random(seed);
            slot_state = rnd[23:0];
            slot_state[2*`CART_MUX_WIDTH + `CART_BIT_RD] = i[0];
            busdir_n = 1'b1;
            repeat (HOLD_CYCLES) next_drive();
            rnd = $random(seed);
            dout      = rnd[7:0];
            host_byte = rnd[15:8];
            busdir_n  = 1'b0;
            #(SAMPLE_DLY - DRIVE_DLY);
            checks++;
            if (cart_busdir_n !== i[0])
                report_mismatch("cart_busdir_n", 32'(cart_busdir_n), 32'(i[0]));
            if (i[0] == 1'b0) begin
                if (cart_data !== dout) report_mismatch("cart_data", 32'(cart_data), 32'(dout));
            end else begin
                wait_din(host_byte);
            end
            next_drive();
            rnd = $random(seed);
            host_byte = rnd[7:0];
            busdir_n  = 1'b1;
            #(SAMPLE_DLY - DRIVE_DLY);
            if (cart_busdir_n !== 1'b1)
                report_mismatch("cart_busdir_n", 32'(cart_busdir_n), 32'h1);
            wait_din(host_byte);
        end

        // the first edge to sample a new high is the next rising edge
        next_drive();
        for (int i = 0; i < NUM_CLOCK_TESTS; i++) begin
            rnd = $random(seed);
            high_len = 2 + int'(rnd[2:0]);
            low_len  = 2 + int'(rnd[6:4]);
            cart_clock = 1'b1;
            rising_edges++;
            pulse_due.push_back(cycle + 1 + CLK_EN_EDGES);
            repeat (high_len) next_drive();
            cart_clock = 1'b0;
            repeat (low_len) next_drive();
        end
        repeat (CLK_EN_EDGES + 4) next_drive();
        checks++;
        if (pulse_count != rising_edges)
            report_mismatch("clk_en pulse count", 32'(pulse_count), 32'(rising_edges));

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+common
common/cart_bus_pkg.sv
hdl/pin_filter.sv
mux_scan/mux_scanner.sv
mux_scan/bus_signal_capture.sv
hdl/cart_data_port.sv
hdl/cart_clock_edge.sv
hdl/cart_bus_top.sv
tests/cart_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the cartridge bus testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module cart_bus_tb -f all.f -o cart_bus_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cart_bus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
